/* host_io_testdata.txt */
# mask (1 proc, 2 load, 3 both), proc: wr addr wdata rdata err, load: wr addr wdata rdata err
# then trace_en_o finish_o all_finished_o after the line, all fields hex
1 1 0010 deadbeef 00000000 0 0 0000 00000000 00000000 0 000 0 0
2 0 0000 00000000 00000000 0 1 0011 cafef00d 00000000 0 000 0 0
1 0 0010 00000000 deadbeef 0 0 0000 00000000 00000000 0 000 0 0
2 0 0000 00000000 00000000 0 0 0010 00000000 deadbeef 0 000 0 0
1 0 0011 00000000 cafef00d 0 0 0000 00000000 00000000 0 000 0 0
1 1 0110 12345678 00000000 1 0 0000 00000000 00000000 0 000 0 0
1 0 0100 00000000 00000000 1 0 0000 00000000 00000000 0 000 0 0
2 0 0000 00000000 00000000 0 1 7fff 55555555 00000000 1 000 0 0
1 0 0010 00000000 deadbeef 0 0 0000 00000000 00000000 0 000 0 0
1 1 8000 ffffffff 00000000 0 0 0000 00000000 00000000 0 7ff 0 0
1 0 8000 00000000 000007ff 0 0 0000 00000000 00000000 0 7ff 0 0
2 0 0000 00000000 00000000 0 1 8000 00000405 00000000 0 405 0 0
2 0 0000 00000000 00000000 0 0 8000 00000000 00000405 0 405 0 0
1 1 8001 00000000 00000000 0 0 0000 00000000 00000000 0 405 1 0
1 0 8001 00000000 00000001 0 0 0000 00000000 00000000 0 405 1 0
2 0 0000 00000000 00000000 0 1 8001 00000002 00000000 1 405 1 0
2 0 0000 00000000 00000000 0 1 8001 80000000 00000000 1 405 1 0
2 0 0000 00000000 00000000 0 1 8001 00000001 00000000 0 405 3 1
1 0 8001 00000000 00000003 0 0 0000 00000000 00000000 0 405 3 1
1 0 8002 00000000 00000000 1 0 0000 00000000 00000000 0 405 3 1
2 0 0000 00000000 00000000 0 0 8003 00000000 00000000 1 405 3 1
3 1 0020 11111111 00000000 0 1 0021 22222222 00000000 0 405 3 1
3 0 0021 00000000 22222222 0 0 0020 00000000 11111111 0 405 3 1
3 1 8000 00000003 00000000 0 0 0010 00000000 deadbeef 0 003 3 1
3 0 8000 00000000 00000003 0 1 0030 a5a5a5a5 00000000 0 003 3 1
3 0 0030 00000000 a5a5a5a5 0 0 8001 00000000 00000003 0 003 3 1
3 1 0040 0badc0de 00000000 0 1 0140 77777777 00000000 1 003 3 1
3 0 0040 00000000 0badc0de 0 0 0011 00000000 cafef00d 0 003 3 1

/* flist.f */
io_pkg.sv
apb_port.sv
host_bus.sv
host_regs.sv
dram_store.sv
host_io_top.sv
tb_host_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary -f flist.f --top-module tb_host_io -o sim_host_io
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_host_io)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1

/* tb_host_io.sv */
`timescale 1ns/100ps

module tb_host_io;

  localparam string DATA_FILE = "host_io_testdata.txt";
  localparam int    MAX_VEC   = 64;

  typedef struct packed {
    logic                       wr;
    logic [io_pkg::ADDR_W-1:0]  addr;
    logic [io_pkg::DATA_W-1:0]  wdata;
    logic [io_pkg::DATA_W-1:0]  rdata;
    logic                       err;
  } xfer_t;

  // Expected sideband values hold after both transfers of a line
  typedef struct packed {
    logic [1:0]   mask;
    xfer_t        proc_x;
    xfer_t        load_x;
    logic [10:0]  en;
    logic [1:0]   fin;
    logic         all_fin;
  } vec_t;

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       proc_psel_i, proc_penable_i, proc_pwrite_i;
  logic                       load_psel_i, load_penable_i, load_pwrite_i;
  logic [io_pkg::ADDR_W-1:0]  proc_paddr_i, load_paddr_i;
  logic [io_pkg::DATA_W-1:0]  proc_pwdata_i, load_pwdata_i;
  logic [io_pkg::DATA_W-1:0]  proc_prdata_o, load_prdata_o;
  logic                       proc_pready_o, proc_pslverr_o;
  logic                       load_pready_o, load_pslverr_o;
  io_pkg::trace_en_t          trace_en_o;
  logic [10:0]                en_bits;
  logic [1:0]                 finish_o;
  logic                       all_finished_o;

  vec_t  vecs [MAX_VEC];
  int    nvec;
  int    errors;
  int    checks;
  int    cycle_cnt = 0;
  int    cycle_limit;

  host_io_top uut (.*);

  assign en_bits = trace_en_o;

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: the run was stopped after %0d cycles", cycle_cnt);
      errors = errors + 1;
      report_and_finish();
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic xfer_t make_xfer(input logic [31:0] w, input logic [31:0] a,
                                      input logic [31:0] wd, input logic [31:0] rd,
                                      input logic [31:0] e);
    return '{wr: w[0], addr: a[io_pkg::ADDR_W-1:0], wdata: wd, rdata: rd, err: e[0]};
  endfunction

  task automatic load_vectors();
    int           fd;
    int           code;
    string        line;
    logic [31:0]  f [14];
    nvec = 0;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0)
      $display("Cannot open the data file %s", DATA_FILE);
    else
    begin
      while (!$feof(fd))
      begin
        code = $fgets(line, fd);
        if (code > 0 && line[0] != "#" && nvec < MAX_VEC)
        begin
          code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                         f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
          if (code == 14)
          begin
            vecs[nvec] = '{mask: f[0][1:0],
                           proc_x: make_xfer(f[1], f[2], f[3], f[4], f[5]),
                           load_x: make_xfer(f[6], f[7], f[8], f[9], f[10]),
                           en: f[11][10:0], fin: f[12][1:0], all_fin: f[13][0]};
            nvec = nvec + 1;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Read data only matters for reads
  task automatic score_transfer(input string name, input int i, input xfer_t x,
                                input logic [31:0] rdata, input logic err);
    check_value(32'(err), 32'(x.err), $sformatf("vector %0d %s pslverr", i, name));
    if (!x.wr)
      check_value(rdata, x.rdata, $sformatf("vector %0d %s prdata", i, name));
  endtask

  task automatic run_vector(input int i);
    vec_t  v;
    logic  p_done;
    logic  l_done;
    int    start_cyc;
    int    p_cyc;
    int    l_cyc;
    v = vecs[i];
    p_done = !v.mask[0];
    l_done = !v.mask[1];
    p_cyc = 0;
    l_cyc = 0;
    @(posedge clk_i);
    proc_psel_i   <= v.mask[0];
    proc_pwrite_i <= v.proc_x.wr;
    proc_paddr_i  <= v.proc_x.addr;
    proc_pwdata_i <= v.proc_x.wdata;
    load_psel_i   <= v.mask[1];
    load_pwrite_i <= v.load_x.wr;
    load_paddr_i  <= v.load_x.addr;
    load_pwdata_i <= v.load_x.wdata;
    @(posedge clk_i);
    proc_penable_i <= v.mask[0];
    load_penable_i <= v.mask[1];
    // Counter has not stepped yet at this edge
    start_cyc = cycle_cnt + 1;
    // Each port is held until its own pready
    while (!(p_done && l_done))
    begin
      @(negedge clk_i);
      if (!p_done && proc_pready_o)
      begin
        score_transfer("proc", i, v.proc_x, proc_prdata_o, proc_pslverr_o);
        p_done = 1'b1;
        p_cyc  = cycle_cnt;
      end
      if (!l_done && load_pready_o)
      begin
        score_transfer("load", i, v.load_x, load_prdata_o, load_pslverr_o);
        l_done = 1'b1;
        l_cyc  = cycle_cnt;
      end
      @(posedge clk_i);
      if (p_done)
      begin
        proc_psel_i    <= 1'b0;
        proc_penable_i <= 1'b0;
      end
      if (l_done)
      begin
        load_psel_i    <= 1'b0;
        load_penable_i <= 1'b0;
      end
    end
    @(negedge clk_i);
    check_value(32'(en_bits), 32'(v.en), $sformatf("vector %0d trace_en_o", i));
    check_value(32'(finish_o), 32'(v.fin), $sformatf("vector %0d finish_o", i));
    check_value(32'(all_finished_o), 32'(v.all_fin), $sformatf("vector %0d all_finished_o", i));
    // Shared bus serializes the pair
    if (v.mask == 2'b11)
    begin
      check_value(32'(p_cyc != l_cyc), 32'd1, $sformatf("vector %0d separate readies", i));
      check_value(32'(((p_cyc > l_cyc) ? p_cyc : l_cyc) - start_cyc >= 3), 32'd1,
                  $sformatf("vector %0d later pready delay", i));
    end
  endtask

  task automatic report_and_finish();
    $display("Run finished with %0d checks and %0d errors", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  endtask

  initial
  begin
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    proc_psel_i    = 1'b0;
    proc_penable_i = 1'b0;
    proc_pwrite_i  = 1'b0;
    proc_paddr_i   = '0;
    proc_pwdata_i  = '0;
    load_psel_i    = 1'b0;
    load_penable_i = 1'b0;
    load_pwrite_i  = 1'b0;
    load_paddr_i   = '0;
    load_pwdata_i  = '0;
    errors = 0;
    checks = 0;
    load_vectors();
    cycle_limit = nvec * 20 + 100;
    if (nvec == 0)
    begin
      $display("No test vectors were read, so nothing was tested");
      errors = errors + 1;
    end
    else
    begin
      repeat (5) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_value(32'(proc_pready_o), 32'd0, "proc pready after reset");
      check_value(32'(load_pready_o), 32'd0, "load pready after reset");
      check_value(32'(en_bits), 32'd0, "trace_en_o after reset");
      check_value(32'(finish_o), 32'd0, "finish_o after reset");
      check_value(32'(all_finished_o), 32'd0, "all_finished_o after reset");
      for (int i = 0; i < nvec; i++)
        run_vector(i);
    end
    report_and_finish();
  end

endmodule

/* host_io_top.sv */
`timescale 1ns/100ps

module host_io_top #(
  parameter int MEM_WORDS = 256,
  parameter int NUM_HARTS = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       proc_psel_i,
  input  logic                       proc_penable_i,
  input  logic                       proc_pwrite_i,
  input  logic [io_pkg::ADDR_W-1:0]  proc_paddr_i,
  input  logic [io_pkg::DATA_W-1:0]  proc_pwdata_i,
  output logic [io_pkg::DATA_W-1:0]  proc_prdata_o,
  output logic                       proc_pready_o,
  output logic                       proc_pslverr_o,
  input  logic                       load_psel_i,
  input  logic                       load_penable_i,
  input  logic                       load_pwrite_i,
  input  logic [io_pkg::ADDR_W-1:0]  load_paddr_i,
  input  logic [io_pkg::DATA_W-1:0]  load_pwdata_i,
  output logic [io_pkg::DATA_W-1:0]  load_prdata_o,
  output logic                       load_pready_o,
  output logic                       load_pslverr_o,
  output io_pkg::trace_en_t          trace_en_o,
  output logic [NUM_HARTS-1:0]       finish_o,
  output logic                       all_finished_o
);

  logic              proc_req_valid, proc_grant, proc_rsp_valid;
  logic              load_req_valid, load_grant, load_rsp_valid;
  logic              host_valid, mem_valid;
  io_pkg::bus_req_t  proc_req, load_req, tgt_req;
  io_pkg::bus_rsp_t  proc_rsp, load_rsp, host_rsp, mem_rsp;

  apb_port u_proc_port (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .psel_i(proc_psel_i), .penable_i(proc_penable_i), .pwrite_i(proc_pwrite_i),
    .paddr_i(proc_paddr_i), .pwdata_i(proc_pwdata_i), .prdata_o(proc_prdata_o),
    .pready_o(proc_pready_o), .pslverr_o(proc_pslverr_o),
    .req_valid_o(proc_req_valid), .req_o(proc_req), .grant_i(proc_grant),
    .rsp_valid_i(proc_rsp_valid), .rsp_i(proc_rsp)
  );

  apb_port u_load_port (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .psel_i(load_psel_i), .penable_i(load_penable_i), .pwrite_i(load_pwrite_i),
    .paddr_i(load_paddr_i), .pwdata_i(load_pwdata_i), .prdata_o(load_prdata_o),
    .pready_o(load_pready_o), .pslverr_o(load_pslverr_o),
    .req_valid_o(load_req_valid), .req_o(load_req), .grant_i(load_grant),
    .rsp_valid_i(load_rsp_valid), .rsp_i(load_rsp)
  );

  // Processor port is p0, loader is p1
  host_bus u_host_bus (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .p0_req_valid_i(proc_req_valid), .p0_req_i(proc_req), .p0_grant_o(proc_grant),
    .p0_rsp_valid_o(proc_rsp_valid), .p0_rsp_o(proc_rsp),
    .p1_req_valid_i(load_req_valid), .p1_req_i(load_req), .p1_grant_o(load_grant),
    .p1_rsp_valid_o(load_rsp_valid), .p1_rsp_o(load_rsp),
    .host_valid_o(host_valid), .mem_valid_o(mem_valid), .tgt_req_o(tgt_req),
    .host_rsp_i(host_rsp), .mem_rsp_i(mem_rsp)
  );

  host_regs #(.NUM_HARTS(NUM_HARTS)) u_host_regs (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .valid_i(host_valid), .req_i(tgt_req),
    .rsp_o(host_rsp), .trace_en_o(trace_en_o), .finish_o(finish_o),
    .all_finished_o(all_finished_o)
  );

  dram_store #(.MEM_WORDS(MEM_WORDS)) u_dram_store (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .valid_i(mem_valid), .req_i(tgt_req),
    .rsp_o(mem_rsp)
  );

endmodule

/* dram_store.sv */
`timescale 1ns/100ps

module dram_store #(
  parameter int MEM_WORDS = 256
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  io_pkg::bus_req_t  req_i,
  output io_pkg::bus_rsp_t  rsp_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int AW    = io_pkg::ADDR_W;

  logic [io_pkg::DATA_W-1:0]  mem [MEM_WORDS];
  logic                       in_range;
  logic                       is_write;
  logic [IDX_W-1:0]           idx;
  io_pkg::bus_rsp_t           rsp_q;

  assign in_range = (req_i.addr < AW'(MEM_WORDS));
  assign is_write = (req_i.op == io_pkg::OP_WRITE);
  assign idx      = req_i.addr[IDX_W-1:0];

  always_ff @(posedge clk_i)
  begin
    if (valid_i && in_range && is_write)
      mem[idx] <= req_i.wdata;
  end

  // Out of range reads back zero with err
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      rsp_q <= '0;
    else if (valid_i)
    begin
      rsp_q.err <= !in_range;
      if (in_range && !is_write)
        rsp_q.rdata <= mem[idx];
      else
        rsp_q.rdata <= '0;
    end
  end

  assign rsp_o = rsp_q;

endmodule

/* host_regs.sv */
`timescale 1ns/100ps

module host_regs #(
  parameter int NUM_HARTS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  io_pkg::bus_req_t      req_i,
  output io_pkg::bus_rsp_t      rsp_o,
  output io_pkg::trace_en_t     trace_en_o,
  output logic [NUM_HARTS-1:0]  finish_o,
  output logic                  all_finished_o
);

  localparam int HART_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1;
  localparam int OFS_W  = io_pkg::HOST_SEL_BIT;
  localparam int DW     = io_pkg::DATA_W;
  localparam int EN_W   = $bits(io_pkg::trace_en_t);

  io_pkg::trace_en_t     en_q;
  logic [NUM_HARTS-1:0]  finish_q;
  io_pkg::bus_rsp_t      rsp_q;
  logic [OFS_W-1:0]      ofs;
  logic                  is_write;
  logic                  hit_en;
  logic                  hit_fin;
  logic                  hart_ok;

  assign ofs      = req_i.addr[OFS_W-1:0];
  assign is_write = (req_i.op == io_pkg::OP_WRITE);
  assign hit_en   = (ofs == OFS_W'(io_pkg::HOST_EN_OFS));
  assign hit_fin  = (ofs == OFS_W'(io_pkg::HOST_FINISH_OFS));
  assign hart_ok  = (req_i.wdata < DW'(NUM_HARTS));

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      en_q     <= '0;
      finish_q <= '0;
      rsp_q    <= '0;
    end
    else if (valid_i)
    begin
      rsp_q <= '0;
      if (hit_en)
      begin
        if (is_write)
          en_q <= io_pkg::trace_en_t'(req_i.wdata[EN_W-1:0]);
        else
          rsp_q.rdata <= DW'(en_q);
      end
      else if (hit_fin)
      begin
        if (!is_write)
          rsp_q.rdata <= DW'(finish_q);
        else if (hart_ok)
          finish_q[req_i.wdata[HART_W-1:0]] <= 1'b1;
        else
          rsp_q.err <= 1'b1;
      end
      else
        rsp_q.err <= 1'b1;
    end
  end

  assign rsp_o          = rsp_q;
  assign trace_en_o     = en_q;
  assign finish_o       = finish_q;
  assign all_finished_o = &finish_q;

endmodule

/* host_bus.sv */
`timescale 1ns/100ps

module host_bus (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              p0_req_valid_i,
  input  io_pkg::bus_req_t  p0_req_i,
  output logic              p0_grant_o,
  output logic              p0_rsp_valid_o,
  output io_pkg::bus_rsp_t  p0_rsp_o,
  input  logic              p1_req_valid_i,
  input  io_pkg::bus_req_t  p1_req_i,
  output logic              p1_grant_o,
  output logic              p1_rsp_valid_o,
  output io_pkg::bus_rsp_t  p1_rsp_o,
  output logic              host_valid_o,
  output logic              mem_valid_o,
  output io_pkg::bus_req_t  tgt_req_o,
  input  io_pkg::bus_rsp_t  host_rsp_i,
  input  io_pkg::bus_rsp_t  mem_rsp_i
);

  logic              busy_q;
  logic              rr_q;
  logic              owner_q;
  logic              tgt_host_q;
  logic              pick_p1;
  logic              grant_any;
  logic              to_host;
  io_pkg::bus_rsp_t  rsp_mux;

  // rr_q set gives p1 the priority on a tie
  always_comb
  begin
    if (p0_req_valid_i && p1_req_valid_i)
      pick_p1 = rr_q;
    else
      pick_p1 = p1_req_valid_i;
  end

  // Single issue, target answers in the cycle after the grant
  assign grant_any = !busy_q && (p0_req_valid_i || p1_req_valid_i);
  assign p0_grant_o = grant_any && !pick_p1;
  assign p1_grant_o = grant_any && pick_p1;

  assign tgt_req_o    = pick_p1 ? p1_req_i : p0_req_i;
  assign to_host      = tgt_req_o.addr[io_pkg::HOST_SEL_BIT];
  assign host_valid_o = grant_any && to_host;
  assign mem_valid_o  = grant_any && !to_host;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      busy_q     <= 1'b0;
      rr_q       <= 1'b0;
      owner_q    <= 1'b0;
      tgt_host_q <= 1'b0;
    end
    else
    begin
      busy_q <= grant_any;
      if (grant_any)
      begin
        owner_q    <= pick_p1;
        tgt_host_q <= to_host;
        rr_q       <= !pick_p1;
      end
    end
  end

  // Response steered back to the owner only
  assign rsp_mux = tgt_host_q ? host_rsp_i : mem_rsp_i;

  assign p0_rsp_valid_o = busy_q && !owner_q;
  assign p1_rsp_valid_o = busy_q && owner_q;
  assign p0_rsp_o       = rsp_mux;
  assign p1_rsp_o       = rsp_mux;

endmodule

/* apb_port.sv */
`timescale 1ns/100ps

module apb_port (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [io_pkg::ADDR_W-1:0]  paddr_i,
  input  logic [io_pkg::DATA_W-1:0]  pwdata_i,
  output logic [io_pkg::DATA_W-1:0]  prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  output logic                       req_valid_o,
  output io_pkg::bus_req_t           req_o,
  input  logic                       grant_i,
  input  logic                       rsp_valid_i,
  input  io_pkg::bus_rsp_t           rsp_i
);

  io_pkg::port_state_e         state_q;
  logic                        pend_q;
  logic                        err_q;
  logic                        start;
  io_pkg::bus_req_t            req_q;
  logic [io_pkg::DATA_W-1:0]   rdata_q;

  // New transfer seen in its first access cycle
  assign start = (state_q == io_pkg::PORT_IDLE) && psel_i && penable_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= io_pkg::PORT_IDLE;
      pend_q  <= 1'b0;
      err_q   <= 1'b0;
    end
    else
    begin
      case (state_q)
        io_pkg::PORT_IDLE:
        begin
          if (start)
          begin
            state_q <= io_pkg::PORT_WAIT;
            pend_q  <= 1'b1;
          end
        end
        io_pkg::PORT_WAIT:
        begin
          if (grant_i)
            pend_q <= 1'b0;
          if (rsp_valid_i)
          begin
            state_q <= io_pkg::PORT_DONE;
            err_q   <= rsp_i.err;
          end
        end
        default:
          state_q <= io_pkg::PORT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start)
      req_q <= '{op:    (pwrite_i ? io_pkg::OP_WRITE : io_pkg::OP_READ),
                 addr:  paddr_i,
                 wdata: pwdata_i};
    if ((state_q == io_pkg::PORT_WAIT) && rsp_valid_i)
      rdata_q <= rsp_i.rdata;
  end

  assign req_valid_o = (state_q == io_pkg::PORT_WAIT) && pend_q;
  assign req_o       = req_q;
  assign prdata_o    = rdata_q;
  assign pready_o    = (state_q == io_pkg::PORT_DONE);
  assign pslverr_o   = (state_q == io_pkg::PORT_DONE) && err_q;

endmodule

/* io_pkg.sv */
package io_pkg;

  // Bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // Address map, bit 15 set selects the host block
  localparam int HOST_SEL_BIT = 15;

  // Word offsets inside the host block
  localparam int HOST_EN_OFS     = 0;
  localparam int HOST_FINISH_OFS = 1;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  typedef enum logic [1:0] {
    PORT_IDLE = 2'd0,
    PORT_WAIT = 2'd1,
    PORT_DONE = 2'd2
  } port_state_e;

  // First field is the MSB
  typedef struct packed {
    logic icache;
    logic dcache;
    logic lce;
    logic cce;
    logic dram;
    logic vm;
    logic cmt;
    logic core_profile;
    logic pc_profile;
    logic branch_profile;
    logic cosim;
  } trace_en_t;

  typedef struct packed {
    bus_op_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]   rdata;
    logic                err;
  } bus_rsp_t;

endpackage
